// File: verilog/mac_tx_macros.svh
`ifndef MAC_TX_MACROS_SVH
`define MAC_TX_MACROS_SVH

// ----------------------------------------
// frame ring geometry
// ----------------------------------------
`define MAC_SLOT_COUNT      32          // slots in the ring
`define MAC_PACKET_SIZE     402         // bytes per slot

// ----------------------------------------
// wire framing
// ----------------------------------------
`define MAC_PREAMBLE_BYTE   8'h55
`define MAC_SFD_BYTE        8'hD5
`define MAC_PREAMBLE_LEN    7           // preamble bytes before the SFD
`define MAC_GAP_CYCLES      12          // minimum idle cycles between frames

// host command codes
`define MAC_OP_WRITE        8'd3
`define MAC_OP_WRITE_LEN    8'd4
`define MAC_OP_WRITE_NEXT   8'd5

`endif

// File: verilog/mac_tx_pkg.sv
`include "mac_tx_macros.svh"

package mac_tx_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int SLOT_W = $clog2(`MAC_SLOT_COUNT);
    localparam int ADDR_W = $clog2(`MAC_PACKET_SIZE);
    localparam int LEN_W  = $clog2(`MAC_PACKET_SIZE + 1);     // 0 up to a full slot

    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;       // IEEE 802.3 generator
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    typedef logic [SLOT_W-1:0] slot_t;
    typedef logic [ADDR_W-1:0] byte_addr_t;
    typedef logic [LEN_W-1:0]  frame_len_t;
    typedef logic [7:0]        mac_byte_t;

    // ----------------------------------------
    // bundles
    // ----------------------------------------
    typedef struct packed {
        logic [7:0] op;                 // one of the MAC_OP_* codes
        byte_addr_t addr;               // byte offset for a write
        mac_byte_t  value;              // byte to write
    } host_cmd_t;

    typedef struct packed {
        logic      en;                  // GMII TX_EN
        mac_byte_t data;                // GMII TXD
    } gmii_tx_t;

    // One byte of CRC-32, bit 0 of the byte goes out first on the wire.
    // The register is kept in the non reflected form, so the FCS bytes
    // are bit reversed and complemented on the way out.
    function automatic logic [31:0] next_crc32_d8(
        input mac_byte_t   data,
        input logic [31:0] crc
    );
        logic [31:0] c;
        logic        fb;

        c = crc;
        for (int i = 0; i < 8; i++)
        begin
            fb = c[31] ^ data[i];                        // feedback bit
            c  = {c[30:0], 1'b0} ^ (fb ? CRC_POLY : 32'h0);
        end
        return c;
    endfunction

endpackage

// File: verilog/frame_buffer.sv
`timescale 1ns/1ps
`include "mac_tx_macros.svh"

module frame_buffer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   wr_en,
    input  mac_tx_pkg::slot_t      wr_slot,
    input  mac_tx_pkg::byte_addr_t wr_addr,
    input  mac_tx_pkg::mac_byte_t  wr_data,
    input  logic                   clear_en,
    input  mac_tx_pkg::slot_t      clear_slot,
    output mac_tx_pkg::frame_len_t fill_len,
    input  mac_tx_pkg::slot_t      rd_slot,
    input  mac_tx_pkg::byte_addr_t rd_addr,
    output mac_tx_pkg::mac_byte_t  rd_data,
    output mac_tx_pkg::frame_len_t send_len
);
    import mac_tx_pkg::*;

    mac_byte_t  mem   [`MAC_SLOT_COUNT][`MAC_PACKET_SIZE];
    frame_len_t len_q [`MAC_SLOT_COUNT];
    frame_len_t wr_end;                                 // length implied by this write

    assign wr_end = frame_len_t'(wr_addr) + 1'b1;

    // ----------------------------------------
    // byte storage, one read per cycle
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (wr_en)
            mem[wr_slot][wr_addr] <= wr_data;
        rd_data <= mem[rd_slot][rd_addr];               // one cycle latency
    end

    // ----------------------------------------
    // per slot length, highest address plus one
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `MAC_SLOT_COUNT; i++)
                len_q[i] <= '0;
        end
        else
        begin
            if (clear_en)
                len_q[clear_slot] <= '0;                // slot reopened for filling
            if (wr_en && wr_end > len_q[wr_slot])
                len_q[wr_slot] <= wr_end;               // only ever grows
        end
    end

    assign fill_len = len_q[wr_slot];
    assign send_len = len_q[rd_slot];

endmodule

// File: verilog/host_command.sv
`timescale 1ns/1ps
`include "mac_tx_macros.svh"

module host_command (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  mac_tx_pkg::host_cmd_t  cmd,
    output logic                   done,
    output logic [15:0]            result,
    output logic                   wr_en,
    output mac_tx_pkg::slot_t      wr_slot,
    output mac_tx_pkg::byte_addr_t wr_addr,
    output mac_tx_pkg::mac_byte_t  wr_data,
    output logic                   clear_en,
    output mac_tx_pkg::slot_t      clear_slot,
    input  mac_tx_pkg::frame_len_t fill_len,
    output logic                   frame_ready,
    output mac_tx_pkg::slot_t      send_slot,
    input  logic                   frame_sent
);
    import mac_tx_pkg::*;

    localparam int COUNT_W = SLOT_W + 1;

    slot_t              fill_q;                         // slot the host is filling
    slot_t              send_q;                         // oldest committed slot
    logic [COUNT_W-1:0] count_q;                        // committed and not yet sent
    logic               addr_ok;
    logic               ring_full;
    logic               commit;

    assign addr_ok   = cmd.addr < `MAC_PACKET_SIZE;
    assign ring_full = count_q == COUNT_W'(`MAC_SLOT_COUNT - 1);   // one slot stays free
    assign commit    = start && cmd.op == `MAC_OP_WRITE_NEXT && !ring_full;

    // ----------------------------------------
    // command decode, done one cycle later
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            done     <= 1'b0;
            result   <= '0;
            wr_en    <= 1'b0;
            clear_en <= 1'b0;
            fill_q   <= '0;
        end
        else
        begin
            done     <= start;
            wr_en    <= 1'b0;
            clear_en <= 1'b0;
            if (start)
            begin
                case (cmd.op)
                    `MAC_OP_WRITE:
                    begin
                        wr_en  <= addr_ok;              // out of range writes are dropped
                        result <= addr_ok ? 16'd0 : 16'd1;
                    end
                    `MAC_OP_WRITE_LEN:
                        result <= 16'(fill_len);
                    `MAC_OP_WRITE_NEXT:
                    begin
                        result <= ring_full ? 16'd1 : 16'd0;
                        if (commit)
                        begin
                            fill_q   <= fill_q + 1'b1;
                            clear_en <= 1'b1;           // new fill slot starts empty
                        end
                    end
                    default:
                        result <= 16'd1;                // unknown op
                endcase
            end
        end
    end

    // write payload, consumed the cycle after start
    always_ff @(posedge clock)
    begin
        if (start)
        begin
            wr_addr <= cmd.addr;
            wr_data <= cmd.value;
        end
    end

    // ----------------------------------------
    // ring pointers
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            send_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (frame_sent)
                send_q <= send_q + 1'b1;
            case ({commit, frame_sent})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;           // both cancel out
            endcase
        end
    end

    assign frame_ready = count_q != '0;
    assign send_slot   = send_q;
    assign wr_slot     = fill_q;
    assign clear_slot  = fill_q;

endmodule

// File: verilog/gmii_tx_framer.sv
`timescale 1ns/1ps
`include "mac_tx_macros.svh"

module gmii_tx_framer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   frame_ready,
    input  mac_tx_pkg::slot_t      send_slot,
    input  mac_tx_pkg::frame_len_t send_len,
    output mac_tx_pkg::slot_t      rd_slot,
    output mac_tx_pkg::byte_addr_t rd_addr,
    input  mac_tx_pkg::mac_byte_t  rd_data,
    output mac_tx_pkg::gmii_tx_t   tx,
    output logic                   frame_sent
);
    import mac_tx_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_PREAMBLE,
        S_SFD,
        S_DATA,
        S_FCS3,
        S_FCS2,
        S_FCS1,
        S_FCS0,
        S_GAP
    } state_t;

    state_t      state_q;
    logic [3:0]  cnt_q;                                 // preamble and gap counter
    frame_len_t  byte_cnt_q;                            // data bytes already sent
    slot_t       slot_q;                                // slot being sent
    logic [31:0] crc_q;

    // FCS byte on the wire, reversed and complemented
    function automatic mac_byte_t fcs_byte(input mac_byte_t crc_byte);
        mac_byte_t r;

        for (int i = 0; i < 8; i++)
            r[i] = ~crc_byte[7 - i];
        return r;
    endfunction

    // ----------------------------------------
    // read side, one byte ahead of the wire
    // ----------------------------------------
    assign rd_slot = slot_q;
    assign rd_addr = (state_q == S_DATA) ? byte_addr_t'(byte_cnt_q + 1'b1) : '0;

    // ----------------------------------------
    // transmit FSM
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state_q    <= S_IDLE;
            cnt_q      <= '0;
            byte_cnt_q <= '0;
            slot_q     <= '0;
            crc_q      <= CRC_INIT;
            tx         <= '0;
            frame_sent <= 1'b0;
        end
        else
        begin
            frame_sent <= 1'b0;
            case (state_q)
                S_IDLE:
                begin
                    // ring count still includes the old frame while frame_sent is high
                    if (frame_ready && !frame_sent)
                    begin
                        slot_q     <= send_slot;
                        cnt_q      <= '0;
                        byte_cnt_q <= '0;
                        crc_q      <= CRC_INIT;
                        state_q    <= S_PREAMBLE;
                    end
                end
                S_PREAMBLE:
                begin
                    tx    <= '{en: 1'b1, data: `MAC_PREAMBLE_BYTE};
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == 4'(`MAC_PREAMBLE_LEN - 1))
                        state_q <= S_SFD;
                end
                S_SFD:
                begin
                    tx      <= '{en: 1'b1, data: `MAC_SFD_BYTE};
                    state_q <= (send_len == '0) ? S_FCS3 : S_DATA;   // empty frame is FCS only
                end
                S_DATA:
                begin
                    tx         <= '{en: 1'b1, data: rd_data};
                    crc_q      <= next_crc32_d8(rd_data, crc_q);
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q + 1'b1 == send_len)
                        state_q <= S_FCS3;              // last data byte
                end
                S_FCS3:
                begin
                    tx      <= '{en: 1'b1, data: fcs_byte(crc_q[31:24])};
                    state_q <= S_FCS2;
                end
                S_FCS2:
                begin
                    tx      <= '{en: 1'b1, data: fcs_byte(crc_q[23:16])};
                    state_q <= S_FCS1;
                end
                S_FCS1:
                begin
                    tx      <= '{en: 1'b1, data: fcs_byte(crc_q[15:8])};
                    state_q <= S_FCS0;
                end
                S_FCS0:
                begin
                    tx      <= '{en: 1'b1, data: fcs_byte(crc_q[7:0])};
                    cnt_q   <= '0;
                    state_q <= S_GAP;
                end
                S_GAP:
                begin
                    tx    <= '0;
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == 4'(`MAC_GAP_CYCLES))
                    begin
                        frame_sent <= 1'b1;             // slot goes back to the host
                        state_q    <= S_IDLE;
                    end
                end
                default:
                    state_q <= S_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/mac_tx_top.sv
`timescale 1ns/1ps

module mac_tx_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  mac_tx_pkg::host_cmd_t cmd,
    output logic                  done,
    output logic [15:0]           result,
    output mac_tx_pkg::gmii_tx_t  tx
);
    import mac_tx_pkg::*;

    // ----------------------------------------
    // host to buffer
    // ----------------------------------------
    logic       wr_en;
    slot_t      wr_slot;
    byte_addr_t wr_addr;
    mac_byte_t  wr_data;
    logic       clear_en;
    slot_t      clear_slot;
    frame_len_t fill_len;

    // ----------------------------------------
    // framer side
    // ----------------------------------------
    logic       frame_ready;
    slot_t      send_slot;
    frame_len_t send_len;
    slot_t      rd_slot;
    byte_addr_t rd_addr;
    mac_byte_t  rd_data;
    logic       frame_sent;

    host_command host_command_inst (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .cmd         (cmd),
        .done        (done),
        .result      (result),
        .wr_en       (wr_en),
        .wr_slot     (wr_slot),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .clear_en    (clear_en),
        .clear_slot  (clear_slot),
        .fill_len    (fill_len),
        .frame_ready (frame_ready),
        .send_slot   (send_slot),
        .frame_sent  (frame_sent)
    );

    frame_buffer frame_buffer_inst (
        .clock       (clock),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_slot     (wr_slot),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .clear_en    (clear_en),
        .clear_slot  (clear_slot),
        .fill_len    (fill_len),
        .rd_slot     (rd_slot),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .send_len    (send_len)
    );

    gmii_tx_framer gmii_tx_framer_inst (
        .clock       (clock),
        .reset       (reset),
        .frame_ready (frame_ready),
        .send_slot   (send_slot),
        .send_len    (send_len),
        .rd_slot     (rd_slot),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .tx          (tx),
        .frame_sent  (frame_sent)
    );

endmodule

// File: tests/mac_tx_sva.sv
`timescale 1ns/1ps
`include "mac_tx_macros.svh"

module mac_tx_sva (
    input logic                 clock,
    input logic                 reset,
    input logic                 start,
    input logic                 done,
    input mac_tx_pkg::gmii_tx_t tx
);
    logic [7:0] idle_run;                               // low cycles since tx.en fell
    logic       seen_frame;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            idle_run   <= '0;
            seen_frame <= 1'b0;
        end
        else if (tx.en)
        begin
            idle_run   <= '0;
            seen_frame <= 1'b1;
        end
        else if (idle_run != 8'hFF)
            idle_run <= idle_run + 1'b1;                // saturates
    end

    // ----------------------------------------
    // command port
    // ----------------------------------------
    done_after_start: assert property (@(posedge clock) disable iff (reset)
        done |-> $past(start))
        else $error("done without a start in the cycle before");

    done_single: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else $error("done high for two cycles");

    // ----------------------------------------
    // transmit bus
    // ----------------------------------------
    tx_quiet_in_reset: assert property (@(posedge clock)
        reset |=> !tx.en ##1 !tx.en)
        else $error("tx.en high during or right after reset");

    tx_gap: assert property (@(posedge clock) disable iff (reset)
        $rose(tx.en) && seen_frame |-> idle_run >= `MAC_GAP_CYCLES)
        else $error("inter-frame gap shorter than the minimum");

endmodule

bind mac_tx_top mac_tx_sva mac_tx_sva_inst (
    .clock (clock),
    .reset (reset),
    .start (start),
    .done  (done),
    .tx    (tx)
);

// File: tests/mac_tx_tb.sv
`timescale 1ns/1ps
`include "mac_tx_macros.svh"

module mac_tx_tb;
    import mac_tx_pkg::*;

    localparam int unsigned SEED = 32'h1cf3779d;
    localparam int RANDOM_FRAMES = 40;
    localparam int BURST_FRAMES  = `MAC_SLOT_COUNT + 2;
    localparam int FRAME_COUNT   = RANDOM_FRAMES + 1 + BURST_FRAMES;
    localparam int FRAME_CYCLES  = 8 + `MAC_PACKET_SIZE + 4 + 13 + 3 * `MAC_PACKET_SIZE;
    localparam int MARGIN_CYCLES = 2000;
    localparam int RETRY_LIMIT   = 1000;                // commit attempts per refused frame

    logic        clock;
    logic        reset;
    logic        start;
    host_cmd_t   cmd;
    logic        done;
    logic [15:0] result;
    gmii_tx_t    tx;

    logic [7:0] exp_bytes[$];                           // expected wire bytes of all frames
    int         exp_lens[$];
    logic [7:0] cap_bytes[$];                           // captured wire bytes
    int         cap_lens[$];

    int result_errors;
    int frame_errors;
    int other_errors;
    int committed_total;
    int freed_total;
    int compared_total;
    int pending_at_start;                               // unfreed frames when a command is driven

    mac_tx_top mac_tx_top_inst (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .cmd    (cmd),
        .done   (done),
        .result (result),
        .tx     (tx)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [31:0] crc32_ref(input logic [7:0] data[$]);
        logic [31:0] c;

        c = 32'hFFFF_FFFF;
        foreach (data[i])
        begin
            c = c ^ {24'h0, data[i]};
            for (int b = 0; b < 8; b++)
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return ~c;
    endfunction

    function automatic void expect_frame(input logic [7:0] data[$]);
        logic [31:0] fcs;

        fcs = crc32_ref(data);
        repeat (`MAC_PREAMBLE_LEN) exp_bytes.push_back(`MAC_PREAMBLE_BYTE);
        exp_bytes.push_back(`MAC_SFD_BYTE);
        foreach (data[i])
            exp_bytes.push_back(data[i]);
        for (int k = 0; k < 4; k++)
            exp_bytes.push_back(8'(fcs >> (8 * k)));   // lowest byte first
        exp_lens.push_back(data.size() + 12);
    endfunction

    // ----------------------------------------
    // host command port
    // ----------------------------------------
    task automatic issue_command(input logic [7:0] op, input int addr, input logic [7:0] value,
                                 output logic [15:0] res);
        int waited;

        @(posedge clock);
        #1;
        start            = 1'b1;
        cmd.op           = op;
        cmd.addr         = byte_addr_t'(addr);
        cmd.value        = value;
        pending_at_start = committed_total - freed_total;
        @(posedge clock);
        #1;
        start  = 1'b0;
        waited = 0;
        while (!done && waited < 4)
        begin
            @(posedge clock);
            #1;
            waited++;
        end
        assert (done)
        else
        begin
            other_errors++;
            $display("command %0d got no done pulse", op);
        end
        res = result;
    endtask

    task automatic write_byte(input int addr, input logic [7:0] value, input logic [15:0] want);
        logic [15:0] res;

        issue_command(`MAC_OP_WRITE, addr, value, res);
        assert (res == want)
        else
        begin
            result_errors++;
            $display("ERROR at %0t: result (write %0d) expected %0d got %0d",
                     $time, addr, want, res);
        end
    endtask

    task automatic check_fill_len(input int want);
        logic [15:0] res;

        issue_command(`MAC_OP_WRITE_LEN, 0, 8'h00, res);
        assert (res == 16'(want))
        else
        begin
            result_errors++;
            $display("ERROR at %0t: result (length) expected %0d got %0d", $time, want, res);
        end
    endtask

    task automatic load_frame(input logic [7:0] data[$]);
        foreach (data[i])
            write_byte(i, data[i], 16'd0);
    endtask

    task automatic commit_frame(input logic [7:0] data[$], output logic accepted);
        logic [15:0] res;
        logic [15:0] want;

        issue_command(`MAC_OP_WRITE_NEXT, 0, 8'h00, res);
        want = (pending_at_start >= `MAC_SLOT_COUNT - 1) ? 16'd1 : 16'd0;   // full ring refuses
        assert (res == want)
        else
        begin
            result_errors++;
            $display("ERROR at %0t: result (commit, %0d pending) expected %0d got %0d",
                     $time, pending_at_start, want, res);
        end
        accepted = (want == 16'd0);
        if (accepted)
        begin
            committed_total++;
            expect_frame(data);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d result, %0d frame, %0d other, %0d frames compared",
                 result_errors, frame_errors, other_errors, compared_total);
    endtask

    // ----------------------------------------
    // capture, slot freeing and compare
    // ----------------------------------------
    initial
    begin
        int   cur_len;
        int   idle_run;
        logic in_frame;
        logic seen_frame;

        cur_len    = 0;
        idle_run   = 0;
        in_frame   = 1'b0;
        seen_frame = 1'b0;
        forever
        begin
            @(negedge clock);
            if (tx.en)
            begin
                if (!in_frame)
                begin
                    assert (!seen_frame || idle_run >= `MAC_GAP_CYCLES)
                    else
                    begin
                        frame_errors++;
                        $display("ERROR at %0t: tx.en gap expected >= %0d got %0d",
                                 $time, `MAC_GAP_CYCLES, idle_run);
                    end
                    cur_len = 0;
                end
                in_frame = 1'b1;
                cap_bytes.push_back(tx.data);
                cur_len++;
            end
            else
            begin
                if (in_frame)
                begin
                    cap_lens.push_back(cur_len);
                    seen_frame = 1'b1;
                    idle_run   = 0;
                end
                in_frame = 1'b0;
                idle_run++;
            end
        end
    end

    // slot is freed gap + 1 cycles after tx.en falls
    initial
    begin
        logic en_prev;

        en_prev = 1'b0;
        forever
        begin
            @(negedge clock);
            if (en_prev && !tx.en)
            begin
                en_prev = 1'b0;
                repeat (`MAC_GAP_CYCLES + 1) @(posedge clock);
                freed_total++;
            end
            else
                en_prev = tx.en;
        end
    end

    initial
    begin
        int         got_len;
        int         want_len;
        logic [7:0] got;
        logic [7:0] want;

        forever
        begin
            @(posedge clock);
            if (cap_lens.size() != 0)
            begin
                got_len = cap_lens.pop_front();
                want_len = 0;
                if (exp_lens.size() == 0)
                begin
                    other_errors++;
                    $display("a frame of %0d bytes was sent that was never committed", got_len);
                end
                else
                    want_len = exp_lens.pop_front();
                assert (got_len == want_len)
                else
                begin
                    frame_errors++;
                    $display("ERROR at %0t: tx.en cycles expected %0d got %0d",
                             $time, want_len, got_len);
                end
                for (int i = 0; i < got_len || i < want_len; i++)
                begin
                    got  = 8'h00;
                    want = 8'h00;
                    if (i < got_len)
                        got = cap_bytes.pop_front();
                    if (i < want_len)
                        want = exp_bytes.pop_front();
                    assert (i >= got_len || i >= want_len || got == want)
                    else
                    begin
                        frame_errors++;
                        $display("ERROR at %0t: tx.data byte %0d of frame %0d expected %h got %h",
                                 $time, i, compared_total, want, got);
                    end
                end
                compared_total++;
            end
        end
    end

    initial
    begin
        repeat (FRAME_COUNT * FRAME_CYCLES + MARGIN_CYCLES) @(posedge clock);
        $display("timeout: %0d of %0d committed frames seen on tx",
                 compared_total, committed_total);
        print_counts();
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial
    begin
        logic [7:0] data[$];
        logic       accepted;
        int         want_len;
        int         addr;
        int         refusals;
        int         tries;

        void'($urandom(SEED));
        start = 1'b0;
        cmd   = '0;
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int f = 0; f < RANDOM_FRAMES; f++)
        begin
            data.delete();
            repeat ($urandom_range(60, 1)) data.push_back(8'($urandom));
            load_frame(data);
            check_fill_len(data.size());
            commit_frame(data, accepted);
        end

        // out of order writes into the fresh fill slot
        check_fill_len(0);
        want_len = 0;
        repeat (12)
        begin
            addr = $urandom_range(`MAC_PACKET_SIZE - 1, 0);
            write_byte(addr, 8'($urandom), 16'd0);
            if (addr + 1 > want_len)
                want_len = addr + 1;
            check_fill_len(want_len);
        end

        // full size frame and writes past the end
        data.delete();
        repeat (`MAC_PACKET_SIZE) data.push_back(8'($urandom));
        load_frame(data);
        check_fill_len(`MAC_PACKET_SIZE);
        write_byte(`MAC_PACKET_SIZE, 8'hEE, 16'd1);
        write_byte($urandom_range(511, `MAC_PACKET_SIZE + 1), 8'hEE, 16'd1);
        check_fill_len(`MAC_PACKET_SIZE);
        commit_frame(data, accepted);

        // one byte frames back to back while the long frame is on the wire
        refusals = 0;
        for (int f = 0; f < BURST_FRAMES; f++)
        begin
            data.delete();
            data.push_back(8'($urandom));
            write_byte(0, data[0], 16'd0);
            commit_frame(data, accepted);
            tries = 0;
            if (!accepted)
                refusals++;
            while (!accepted && tries < RETRY_LIMIT)
            begin
                commit_frame(data, accepted);
                tries++;
            end
            assert (accepted)
            else
            begin
                other_errors++;
                $display("burst frame %0d was still refused after %0d retries", f, tries);
            end
        end
        assert (refusals > 0)
        else
        begin
            other_errors++;
            $display("no commit was refused during the burst");
        end

        while (compared_total < committed_total)
            @(posedge clock);
        repeat (40) @(posedge clock);
        assert (cap_lens.size() == 0 && exp_lens.size() == 0)
        else
        begin
            other_errors++;
            $display("frames left over at the end of the run");
        end

        print_counts();
        if (result_errors + frame_errors + other_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: list.f
+incdir+verilog
verilog/mac_tx_pkg.sv
verilog/frame_buffer.sv
verilog/host_command.sv
verilog/gmii_tx_framer.sv
verilog/mac_tx_top.sv
tests/mac_tx_sva.sv
tests/mac_tx_tb.sv

// File: run.sh
#!/bin/sh
# build and run the MAC transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module mac_tx_tb -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmac_tx_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
